//--- design/vgaPkg.sv
package vgaPkg;

    // ==========================================================
    // Data path types
    // ==========================================================

    // One framebuffer or core data word
    typedef logic [31:0] wordT;

    // Byte lanes of one word
    typedef logic [3:0] byteEnT;

    // Single colour channel
    typedef logic [3:0] colorT;

    // Horizontal or vertical scan position
    typedef logic [9:0] coordT;

    // ==========================================================
    // Standard 640x480 timing
    // ==========================================================

    // Horizontal, in pixel ticks
    localparam int DEF_H_ACTIVE = 640;
    localparam int DEF_H_FRONT = 16;
    localparam int DEF_H_SYNC = 96;
    localparam int DEF_H_BACK = 48;

    // Vertical, in lines
    localparam int DEF_V_ACTIVE = 480;
    localparam int DEF_V_FRONT = 10;
    localparam int DEF_V_SYNC = 2;
    localparam int DEF_V_BACK = 33;

    // Each memory row shown on four display lines
    localparam int DEF_LINE_SHIFT = 2;

endpackage

//--- design/vgaScanIf.sv
interface vgaScanIf;
    import vgaPkg::*;

    // Strobe, high on every second clock
    logic pixelTick;

    // Current scan position
    coordT counterX;
    coordT counterY;

    // Levels for the current position, registered by the pipe
    logic displayActive;
    logic hSyncNext;
    logic vSyncNext;

    // Sync generator side
    modport gen (
        output pixelTick,
        output counterX,
        output counterY,
        output displayActive,
        output hSyncNext,
        output vSyncNext
    );

    // Pixel pipeline side, read only
    modport pipe (
        input pixelTick,
        input counterX,
        input counterY,
        input displayActive,
        input hSyncNext,
        input vSyncNext
    );

endinterface

//--- design/vgaSyncGen.sv
module vgaSyncGen #(
    parameter int hActive = vgaPkg::DEF_H_ACTIVE,
    parameter int hFront = vgaPkg::DEF_H_FRONT,
    parameter int hSyncWidth = vgaPkg::DEF_H_SYNC,
    parameter int hBack = vgaPkg::DEF_H_BACK,
    parameter int vActive = vgaPkg::DEF_V_ACTIVE,
    parameter int vFront = vgaPkg::DEF_V_FRONT,
    parameter int vSyncWidth = vgaPkg::DEF_V_SYNC,
    parameter int vBack = vgaPkg::DEF_V_BACK
) (
    input logic CLK_50,
    input logic reset,
    vgaScanIf.gen scan
);
    import vgaPkg::*;

    // Frame boundaries in counter units
    localparam int hTotal = hActive + hFront + hSyncWidth + hBack;
    localparam int vTotal = vActive + vFront + vSyncWidth + vBack;
    localparam coordT hLast = coordT'(hTotal - 1);
    localparam coordT vLast = coordT'(vTotal - 1);

    // Sync pulse windows, start inclusive and end exclusive
    localparam coordT hSyncStart = coordT'(hActive + hFront);
    localparam coordT hSyncEnd = coordT'(hActive + hFront + hSyncWidth);
    localparam coordT vSyncStart = coordT'(vActive + vFront);
    localparam coordT vSyncEnd = coordT'(vActive + vFront + vSyncWidth);

    logic tickQ;
    coordT counterX;
    coordT counterY;

    // ==========================================================
    // Pixel tick, half of CLK_50
    // ==========================================================
    always_ff @(posedge CLK_50) begin
        if (reset) begin
            tickQ <= 1'b0;
        end else begin
            tickQ <= ~tickQ;
        end
    end

    // ==========================================================
    // Scan counters
    // ==========================================================
    always_ff @(posedge CLK_50) begin
        if (reset) begin
            counterX <= '0;
            counterY <= '0;
        end else if (tickQ) begin
            if (counterX == hLast) begin
                counterX <= '0;
                // Next line, wrap at end of frame
                if (counterY == vLast) begin
                    counterY <= '0;
                end else begin
                    counterY <= counterY + 1'b1;
                end
            end else begin
                counterX <= counterX + 1'b1;
            end
        end
    end

    assign scan.pixelTick = tickQ;
    assign scan.counterX = counterX;
    assign scan.counterY = counterY;

    // Levels one tick ahead of the pins
    assign scan.displayActive = (counterX < coordT'(hActive)) && (counterY < coordT'(vActive));

    // Active low pulses
    assign scan.hSyncNext = !((counterX >= hSyncStart) && (counterX < hSyncEnd));
    assign scan.vSyncNext = !((counterY >= vSyncStart) && (counterY < vSyncEnd));

endmodule

//--- design/vgaFrameBuffer.sv
module vgaFrameBuffer #(
    parameter int depthWords = 2400,
    localparam int addrWidth = $clog2(depthWords)
) (
    input logic CLK_50,
    input logic reset,
    // Core port
    input vgaPkg::wordT writeData,
    input vgaPkg::wordT address,
    input vgaPkg::byteEnT byteEnable,
    input logic writeEnable,
    input logic readEnable,
    output vgaPkg::wordT readData,
    // Scan port
    input logic [addrWidth-1:0] scanAddress,
    output vgaPkg::wordT scanData
);
    import vgaPkg::*;

    // Byte lanes per word
    localparam int numLanes = $bits(byteEnT);

    wordT mem [depthWords];
    logic [addrWidth-1:0] coreIndex;

    // Byte address to word index
    assign coreIndex = address[2 +: addrWidth];

    // ==========================================================
    // Memory array, byte-lane writes and scan read
    // ==========================================================
    always_ff @(posedge CLK_50) begin
        if (writeEnable) begin
            for (int lane = 0; lane < numLanes; lane++) begin
                // Only enabled lanes change
                if (byteEnable[lane]) begin
                    mem[coreIndex][8*lane +: 8] <= writeData[8*lane +: 8];
                end
            end
        end
        // Scan word every cycle, one cycle latency
        scanData <= mem[scanAddress];
    end

    // ==========================================================
    // Core read port
    // ==========================================================

    // Old word on a same-cycle write, held until the next read
    always_ff @(posedge CLK_50) begin
        if (reset) begin
            readData <= '0;
        end else if (readEnable) begin
            readData <= mem[coreIndex];
        end
    end

endmodule

//--- design/vgaPixelPipe.sv
module vgaPixelPipe #(
    parameter int hActive = vgaPkg::DEF_H_ACTIVE,
    parameter int lineShift = vgaPkg::DEF_LINE_SHIFT,
    parameter int addrWidth = 12
) (
    input logic CLK_50,
    input logic reset,
    vgaScanIf.pipe scan,
    // Framebuffer scan port
    output logic [addrWidth-1:0] scanAddress,
    input vgaPkg::wordT scanData,
    // Display pins
    output vgaPkg::colorT RED,
    output vgaPkg::colorT GREEN,
    output vgaPkg::colorT BLUE,
    output logic hSync,
    output logic vSync,
    output logic inDisplayArea
);
    import vgaPkg::*;

    // Memory words in one row
    localparam int wordsPerLine = hActive / 32;

    coordT rowIdx;
    logic [31:0] wordIndex;
    logic [4:0] bitSelQ;
    logic activeQ;
    logic hSyncQ;
    logic vSyncQ;
    logic pixelBit;
    colorT pixelColor;

    // ==========================================================
    // Word address of the scan position
    // ==========================================================

    // Same memory row for 2^lineShift lines
    assign rowIdx = scan.counterY >> lineShift;
    assign wordIndex = 32'(rowIdx) * 32'(wordsPerLine) + 32'(scan.counterX >> 5);
    assign scanAddress = wordIndex[addrWidth-1:0];

    // ==========================================================
    // Alignment with the RAM read
    // ==========================================================

    // Bit position within the word
    always_ff @(posedge CLK_50) begin
        bitSelQ <= scan.counterX[4:0];
    end

    // Levels taken in the same cycle as the address
    always_ff @(posedge CLK_50) begin
        if (reset) begin
            activeQ <= 1'b0;
            hSyncQ <= 1'b1;
            vSyncQ <= 1'b1;
        end else begin
            activeQ <= scan.displayActive;
            hSyncQ <= scan.hSyncNext;
            vSyncQ <= scan.vSyncNext;
        end
    end

    // Black outside the visible area
    assign pixelBit = scanData[bitSelQ] & activeQ;
    assign pixelColor = {4{pixelBit}};

    // ==========================================================
    // Output registers, updated on the pixel tick
    // ==========================================================
    always_ff @(posedge CLK_50) begin
        if (reset) begin
            RED <= '0;
            GREEN <= '0;
            BLUE <= '0;
            hSync <= 1'b1;
            vSync <= 1'b1;
            inDisplayArea <= 1'b0;
        end else if (scan.pixelTick) begin
            // Monochrome, same bit on all channels
            RED <= pixelColor;
            GREEN <= pixelColor;
            BLUE <= pixelColor;
            hSync <= hSyncQ;
            vSync <= vSyncQ;
            inDisplayArea <= activeQ;
        end
    end

endmodule

//--- design/vgaCtrl.sv
module vgaCtrl #(
    parameter int hActive = vgaPkg::DEF_H_ACTIVE,
    parameter int hFront = vgaPkg::DEF_H_FRONT,
    parameter int hSyncWidth = vgaPkg::DEF_H_SYNC,
    parameter int hBack = vgaPkg::DEF_H_BACK,
    parameter int vActive = vgaPkg::DEF_V_ACTIVE,
    parameter int vFront = vgaPkg::DEF_V_FRONT,
    parameter int vSyncWidth = vgaPkg::DEF_V_SYNC,
    parameter int vBack = vgaPkg::DEF_V_BACK,
    parameter int lineShift = vgaPkg::DEF_LINE_SHIFT
) (
    input logic CLK_50,
    input logic reset,
    // Core access
    input vgaPkg::wordT writeData,
    input vgaPkg::wordT address,
    input vgaPkg::byteEnT byteEnable,
    input logic writeEnable,
    input logic readEnable,
    output vgaPkg::wordT readData,
    // VGA pins
    output vgaPkg::colorT RED,
    output vgaPkg::colorT GREEN,
    output vgaPkg::colorT BLUE,
    output logic hSync,
    output logic vSync,
    output logic inDisplayArea
);
    import vgaPkg::*;

    // One word per 32 pixels of each stored row
    localparam int depthWords = (vActive >> lineShift) * (hActive / 32);
    localparam int addrWidth = $clog2(depthWords);

    logic [addrWidth-1:0] scanAddress;
    wordT scanData;

    vgaScanIf scan ();

    // ==========================================================
    // Sync generator
    // ==========================================================
    vgaSyncGen #(
        .hActive(hActive),
        .hFront(hFront),
        .hSyncWidth(hSyncWidth),
        .hBack(hBack),
        .vActive(vActive),
        .vFront(vFront),
        .vSyncWidth(vSyncWidth),
        .vBack(vBack)
    ) syncGen (
        .CLK_50(CLK_50),
        .reset(reset),
        .scan(scan.gen)
    );

    // ==========================================================
    // Framebuffer
    // ==========================================================
    vgaFrameBuffer #(
        .depthWords(depthWords)
    ) frameBuffer (
        .CLK_50(CLK_50),
        .reset(reset),
        .writeData(writeData),
        .address(address),
        .byteEnable(byteEnable),
        .writeEnable(writeEnable),
        .readEnable(readEnable),
        .readData(readData),
        .scanAddress(scanAddress),
        .scanData(scanData)
    );

    // ==========================================================
    // Pixel pipeline
    // ==========================================================
    vgaPixelPipe #(
        .hActive(hActive),
        .lineShift(lineShift),
        .addrWidth(addrWidth)
    ) pixelPipe (
        .CLK_50(CLK_50),
        .reset(reset),
        .scan(scan.pipe),
        .scanAddress(scanAddress),
        .scanData(scanData),
        .RED(RED),
        .GREEN(GREEN),
        .BLUE(BLUE),
        .hSync(hSync),
        .vSync(vSync),
        .inDisplayArea(inDisplayArea)
    );

endmodule

//--- verification/vgaModel.svh
`ifndef VGA_MODEL_SVH
`define VGA_MODEL_SVH

// Expected framebuffer contents, one entry per word
wordT modelMem [numWords];

// Byte-lane write into the model
function automatic void modelWrite(int index, wordT data, byteEnT lanes);
    wordT laneMask;
    laneMask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
    modelMem[idxWidth'(index)] = (modelMem[idxWidth'(index)] & ~laneMask) | (data & laneMask);
endfunction

// Word as last written
function automatic wordT modelWord(int index);
    return modelMem[idxWidth'(index)];
endfunction

// Pixel x of a row is bit x mod 32 of word row * wordsPerLine + x / 32
function automatic logic modelPixel(int row, int x);
    wordT memWord;
    memWord = modelMem[idxWidth'(row * wordsPerLine + x / 32)];
    return memWord[5'(x % 32)];
endfunction

// Same bit on every colour channel
function automatic colorT modelColor(int row, int x);
    return {4{modelPixel(row, x)}};
endfunction

`endif

//--- verification/vgaCtrlTb.sv
module vgaCtrlTb;
    import vgaPkg::*;

    // Small frame of 80 ticks by 12 lines
    localparam int hActive = 64;
    localparam int hFront = 4;
    localparam int hSyncWidth = 8;
    localparam int hBack = 4;
    localparam int vActive = 8;
    localparam int vFront = 1;
    localparam int vSyncWidth = 2;
    localparam int vBack = 1;
    localparam int lineShift = 1;

    localparam int hTotal = hActive + hFront + hSyncWidth + hBack;
    localparam int vTotal = vActive + vFront + vSyncWidth + vBack;
    localparam int frameCycles = 2 * hTotal * vTotal;
    localparam int wordsPerLine = hActive / 32;
    localparam int numWords = (vActive >> lineShift) * wordsPerLine;
    localparam int idxWidth = $clog2(numWords);
    // Longest single wait of two frames
    localparam int waitLimit = 2 * frameCycles;

    // Outputs a wait can watch
    localparam int sigHSync = 0;
    localparam int sigVSync = 1;
    localparam int sigDisplay = 2;

    logic CLK_50 = 1'b0;
    logic reset;
    wordT writeData;
    wordT address;
    byteEnT byteEnable;
    logic writeEnable;
    logic readEnable;
    wordT readData;
    colorT RED;
    colorT GREEN;
    colorT BLUE;
    logic hSync;
    logic vSync;
    logic inDisplayArea;

    logic [15:0] lfsrState = 16'd63030;
    int cycleCount;

    `include "vgaModel.svh"

    vgaCtrl #(
        .hActive(hActive),
        .hFront(hFront),
        .hSyncWidth(hSyncWidth),
        .hBack(hBack),
        .vActive(vActive),
        .vFront(vFront),
        .vSyncWidth(vSyncWidth),
        .vBack(vBack),
        .lineShift(lineShift)
    ) UUT (.*);

    initial begin
        forever #2 CLK_50 = ~CLK_50;
    end

    // ==========================================================
    // Random source
    // ==========================================================

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic lfsrBit();
        logic feedback;
        feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] randomBits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsrBit()};
        end
        return value;
    endfunction

    // ==========================================================
    // Compare tasks
    // ==========================================================
    task automatic stopWithFailure(string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic checkWord(string name, wordT expected, wordT actual);
        if (actual !== expected) begin
            stopWithFailure($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic checkColor(string name, colorT expected, colorT actual);
        if (actual !== expected) begin
            stopWithFailure($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic checkCoord(string name, coordT expected, coordT actual);
        if (actual !== expected) begin
            stopWithFailure($sformatf("ERROR %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic checkLevel(string name, logic expected, logic actual);
        if (actual !== expected) begin
            stopWithFailure($sformatf("ERROR %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // Cycle counts compared in pixel periods plus parity
    task automatic checkCycles(string name, int expected, int actual);
        checkCoord({name, " periods"}, coordT'(expected / 2), coordT'(actual / 2));
        checkCoord({name, " parity"}, coordT'(expected % 2), coordT'(actual % 2));
    endtask

    // ==========================================================
    // Cycle stepping and waits
    // ==========================================================

    // Sample on the falling edge and expect black while blanked
    task automatic nextCycle();
        @(negedge CLK_50);
        cycleCount++;
        if (inDisplayArea === 1'b0) begin
            checkColor("blanking colour", '0, RED | GREEN | BLUE);
        end
    endtask

    function automatic logic sigValue(int which);
        case (which)
            sigHSync: return hSync;
            sigVSync: return vSync;
            default: return inDisplayArea;
        endcase
    endfunction

    task automatic waitFor(int which, logic level, string what);
        int count;
        count = 0;
        while (sigValue(which) !== level) begin
            if (count >= waitLimit) begin
                stopWithFailure($sformatf("Timed out after %0d cycles waiting for %s",
                    count, what));
            end
            nextCycle();
            count++;
        end
    endtask

    // First cycle after a change to level
    task automatic waitEdge(int which, logic level, string what);
        waitFor(which, !level, what);
        waitFor(which, level, what);
    endtask

    // ==========================================================
    // Core port accesses
    // ==========================================================
    task automatic writeWord(int index, wordT data, byteEnT lanes, logic readBack);
        wordT oldWord;
        oldWord = modelWord(index);
        address = wordT'(index * 4);
        writeData = data;
        byteEnable = lanes;
        writeEnable = 1'b1;
        readEnable = readBack;
        nextCycle();
        writeEnable = 1'b0;
        readEnable = 1'b0;
        modelWrite(index, data, lanes);
        // Same-cycle read sees the old word
        if (readBack) begin
            checkWord($sformatf("read during write word %0d", index), oldWord, readData);
        end
    endtask

    task automatic readWord(int index, string name);
        address = wordT'(index * 4);
        readEnable = 1'b1;
        nextCycle();
        readEnable = 1'b0;
        checkWord($sformatf("%s word %0d", name, index), modelWord(index), readData);
        // Held with readEnable low while another word is addressed
        address = wordT'(((index + 1) % numWords) * 4);
        nextCycle();
        checkWord($sformatf("%s hold word %0d", name, index), modelWord(index), readData);
    endtask

    task automatic randomWrites(logic fullWords, logic sameCycleRead);
        int start;
        int stride;
        int index;
        byteEnT lanes;
        // Odd stride visits every word once
        start = int'(randomBits(idxWidth));
        stride = int'(randomBits(idxWidth)) | 1;
        for (int i = 0; i < numWords; i++) begin
            index = (start + stride * i) % numWords;
            // readData still holds another word here
            if (sameCycleRead) begin
                writeWord(index, wordT'(randomBits(32)), byteEnT'(randomBits(4)), 1'b1);
            end
            lanes = fullWords ? 4'hF : byteEnT'(randomBits(4));
            writeWord(index, wordT'(randomBits(32)), lanes, 1'b0);
            readWord(index, "core read");
        end
    endtask

    // ==========================================================
    // Output checks
    // ==========================================================
    task automatic checkResetValues(string when);
        checkLevel({when, " hSync"}, 1'b1, hSync);
        checkLevel({when, " vSync"}, 1'b1, vSync);
        checkLevel({when, " inDisplayArea"}, 1'b0, inDisplayArea);
        checkColor({when, " red"}, '0, RED);
        checkColor({when, " green"}, '0, GREEN);
        checkColor({when, " blue"}, '0, BLUE);
        checkWord({when, " readData"}, '0, readData);
    endtask

    // Called in vertical blanking
    // Line number found by counting display starts
    task automatic checkFrame(string name);
        colorT expected;
        string tag;
        for (int line = 0; line < vActive; line++) begin
            waitFor(sigDisplay, 1'b1, "display line start");
            for (int j = 0; j < 2 * hActive; j++) begin
                // Pixel j/2 held for two cycles
                expected = modelColor(line >> lineShift, j / 2);
                tag = $sformatf("%s line %0d pixel %0d", name, line, j / 2);
                checkLevel({tag, " active"}, 1'b1, inDisplayArea);
                checkColor({tag, " red"}, expected, RED);
                checkColor({tag, " green"}, expected, GREEN);
                checkColor({tag, " blue"}, expected, BLUE);
                nextCycle();
            end
            checkLevel($sformatf("%s line %0d end", name, line), 1'b0, inDisplayArea);
        end
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================
    initial begin
        int startCycle;
        reset = 1'b1;
        writeData = '0;
        address = '0;
        byteEnable = '0;
        writeEnable = 1'b0;
        readEnable = 1'b0;
        cycleCount = 0;

        // Three cycles in reset and one after release
        repeat (3) begin
            nextCycle();
            checkResetValues("during reset");
        end
        reset = 1'b0;
        nextCycle();
        checkResetValues("after reset");

        // Whole words first so byte-lane merges start from known data
        randomWrites(1'b1, 1'b0);
        randomWrites(1'b0, 1'b1);

        // Frame and line timing
        waitEdge(sigVSync, 1'b0, "vSync fall");
        startCycle = cycleCount;
        waitFor(sigVSync, 1'b1, "vSync rise");
        checkCycles("vSync low", 2 * hTotal * vSyncWidth, cycleCount - startCycle);
        waitFor(sigVSync, 1'b0, "next vSync fall");
        checkCycles("vSync period", frameCycles, cycleCount - startCycle);
        waitEdge(sigHSync, 1'b0, "hSync fall");
        startCycle = cycleCount;
        waitFor(sigHSync, 1'b1, "hSync rise");
        checkCycles("hSync low", 2 * hSyncWidth, cycleCount - startCycle);
        waitEdge(sigDisplay, 1'b1, "display start");
        startCycle = cycleCount;
        waitFor(sigDisplay, 1'b0, "display end");
        checkCycles("display line", 2 * hActive, cycleCount - startCycle);

        // Pixel content
        waitEdge(sigVSync, 1'b0, "frame start");
        checkFrame("first frame");

        // Rewrite in vertical blanking for new pixels in the next frame
        waitEdge(sigVSync, 1'b0, "blanking start");
        randomWrites(1'b0, 1'b1);
        checkFrame("updated frame");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- all.f
design/vgaPkg.sv
design/vgaScanIf.sv
design/vgaSyncGen.sv
design/vgaFrameBuffer.sv
design/vgaPixelPipe.sv
design/vgaCtrl.sv
+incdir+verification
verification/vgaCtrlTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the VGA controller testbench with Verilator
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary -f all.f --top-module vgaCtrlTb -Mdir "$BUILD_DIR" -o vgaCtrlSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

"$BUILD_DIR/vgaCtrlSim" > "$LOG_FILE" 2>&1
runStatus=$?
cat "$LOG_FILE"
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1
